// ==== hw/mini_rv_config.svh ====
/*
 * Build-time settings for the mini RV32I system: RAM size, reset PC and
 * the addresses of the memory-mapped test peripherals. Included by every
 * RTL file that needs an address or a width.
 */
`ifndef MINI_RV_CONFIG_SVH
`define MINI_RV_CONFIG_SVH

// byte address width of the RAM, 12 bits gives 1024 words
`define RAM_ADDR_WIDTH 12
`define RAM_WORDS (1 << (`RAM_ADDR_WIDTH - 2))

// first instruction fetched after reset
`define BOOT_ADDR 32'h0000_0080

// pseudo peripherals, all decoded on the data side only
`define STDOUT_ADDR 32'h1000_0000
`define PASS_ADDR 32'h2000_0000
`define FAIL_ADDR 32'h2000_0004
`define EXIT_ADDR 32'h2000_0008

`endif

// ==== hw/mini_rv_pkg.sv ====
/*
 * Types shared by the core and the memory: opcodes of the supported
 * instructions, the RV32I instruction formats with a union that overlays
 * them on one word, and the data request bundle sent from core to RAM.
 */
package mini_rv_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // branch offsets are scattered so that the sign bit stays at bit 31
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t     r;
        i_type_t     i;
        s_type_t     s;
        b_type_t     b;
        u_type_t     u;
        j_type_t     j;
        logic [31:0] raw;
    } instr_u;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        logic [3:0]  be;
    } data_req_t;

endpackage

// ==== hw/mini_rv_core.sv ====
/*
 * Multi-cycle RV32I subset core. Runs LUI, ADDI, ADD, SUB, LW, SW (with
 * SB/SH byte enables), BEQ, BNE and JAL one at a time and stops in HALT on
 * any other opcode. Both memory sides use a req/gnt/rvalid handshake with
 * a single request in flight.
 */
`timescale 1ns/1ns
`include "mini_rv_config.svh"

module mini_rv_core import mini_rv_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        fetch_enable_i,

    output logic        instr_req_o,
    output logic [31:0] instr_addr_o,
    input  logic        instr_gnt_i,
    input  logic        instr_rvalid_i,
    input  logic [31:0] instr_rdata_i,

    output logic        data_req_o,
    output data_req_t   data_req_bus_o,
    input  logic        data_gnt_i,
    input  logic        data_rvalid_i,
    input  logic [31:0] data_rdata_i
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_INSTR,
        EXECUTE,
        MEM,
        WAIT_DATA,
        HALT
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic [31:0] pc_q;
    logic [31:0] pc_d;
    instr_u      instr_q;
    data_req_t   data_req_q;
    opcode_e     opcode;

    logic [31:0] regs [32];
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        rf_we;
    logic [31:0] rf_wdata;

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic [31:0] pc_plus4;
    logic [31:0] pc_target;
    logic        take_branch;

    assign opcode = opcode_e'(instr_q.raw[6:0]);

    // immediates come from different views of the same fetched word
    assign imm_i = {{20{instr_q.i.imm[11]}}, instr_q.i.imm};
    assign imm_s = {{20{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};
    assign imm_b = {{20{instr_q.b.imm12}}, instr_q.b.imm11, instr_q.b.imm10_5,
                    instr_q.b.imm4_1, 1'b0};
    assign imm_u = {instr_q.u.imm, 12'h000};
    assign imm_j = {{12{instr_q.j.imm20}}, instr_q.j.imm19_12, instr_q.j.imm11,
                    instr_q.j.imm10_1, 1'b0};

    // x0 reads as zero and is never written
    assign rs1_val = (instr_q.r.rs1 == 5'd0) ? 32'd0 : regs[instr_q.r.rs1];
    assign rs2_val = (instr_q.r.rs2 == 5'd0) ? 32'd0 : regs[instr_q.r.rs2];

    always_ff @(posedge clk_i) begin
        if (rf_we && instr_q.r.rd != 5'd0) begin
            regs[instr_q.r.rd] <= rf_wdata;
        end
    end

    // one adder serves ADD/ADDI/SUB and the load/store address
    always_comb begin
        case (opcode)
            OP_REG:   alu_b = rs2_val;
            OP_STORE: alu_b = imm_s;
            default:  alu_b = imm_i;
        endcase
    end

    assign alu_res = (opcode == OP_REG && instr_q.r.funct7[5]) ? rs1_val - alu_b
                                                              : rs1_val + alu_b;
    assign pc_plus4  = pc_q + 32'd4;
    assign pc_target = pc_q + ((opcode == OP_JAL) ? imm_j : imm_b);

    // funct3 bit 0 selects BNE over BEQ
    assign take_branch = (rs1_val == rs2_val) ^ instr_q.b.funct3[0];

    always_comb begin
        state_d  = state_q;
        pc_d     = pc_q;
        rf_we    = 1'b0;
        rf_wdata = alu_res;
        case (state_q)
            IDLE: begin
                if (fetch_enable_i) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (instr_gnt_i) begin
                    state_d = WAIT_INSTR;
                end
            end
            WAIT_INSTR: begin
                if (instr_rvalid_i) begin
                    state_d = EXECUTE;
                end
            end
            EXECUTE: begin
                state_d = FETCH;
                pc_d    = pc_plus4;
                case (opcode)
                    OP_LUI: begin
                        rf_we    = 1'b1;
                        rf_wdata = imm_u;
                    end
                    OP_IMM, OP_REG: begin
                        rf_we = 1'b1;
                    end
                    OP_JAL: begin
                        rf_we    = 1'b1;
                        rf_wdata = pc_plus4;
                        pc_d     = pc_target;
                    end
                    OP_BRANCH: begin
                        if (take_branch) begin
                            pc_d = pc_target;
                        end
                    end
                    OP_LOAD, OP_STORE: begin
                        pc_d    = pc_q;
                        state_d = MEM;
                    end
                    default: begin
                        pc_d    = pc_q;
                        state_d = HALT;
                    end
                endcase
            end
            MEM: begin
                if (data_gnt_i) begin
                    state_d = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (data_rvalid_i) begin
                    state_d = FETCH;
                    pc_d    = pc_plus4;
                    if (opcode == OP_LOAD) begin
                        rf_we    = 1'b1;
                        rf_wdata = data_rdata_i;
                    end
                end
            end
            default: begin
                state_d = HALT;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            pc_q    <= `BOOT_ADDR;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    // the request bundle is built once in EXECUTE and held through the handshake
    always_ff @(posedge clk_i) begin
        if (state_q == WAIT_INSTR && instr_rvalid_i) begin
            instr_q.raw <= instr_rdata_i;
        end
        if (state_q == EXECUTE) begin
            data_req_q.addr <= alu_res;
            data_req_q.we   <= (opcode == OP_STORE);
            case (instr_q.s.funct3[1:0])
                2'b00: begin
                    data_req_q.be    <= 4'b0001 << alu_res[1:0];
                    data_req_q.wdata <= {4{rs2_val[7:0]}};
                end
                2'b01: begin
                    data_req_q.be    <= 4'b0011 << {alu_res[1], 1'b0};
                    data_req_q.wdata <= {2{rs2_val[15:0]}};
                end
                default: begin
                    data_req_q.be    <= 4'b1111;
                    data_req_q.wdata <= rs2_val;
                end
            endcase
        end
    end

    assign instr_req_o    = (state_q == FETCH);
    assign instr_addr_o   = pc_q;
    assign data_req_o     = (state_q == MEM);
    assign data_req_bus_o = data_req_q;

    a_instr_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

    a_data_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_req_o && !data_gnt_i |=> data_req_o && $stable(data_req_bus_o));

    // after any grant the memory answers next cycle and nothing new is asked
    a_single_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (instr_req_o && instr_gnt_i) || (data_req_o && data_gnt_i)
        |=> !instr_req_o && !data_req_o && (instr_rvalid_i || data_rvalid_i));

endmodule

// ==== hw/mm_ram.sv ====
/*
 * Single-ported word RAM shared by instruction fetch and data access, with
 * data given priority. Data writes to the peripheral addresses drive the
 * stdout, pass, fail and exit outputs instead of the array. The testbench
 * fills the array through the loader port while the core is held idle.
 */
`timescale 1ns/1ns
`include "mini_rv_config.svh"

module mm_ram import mini_rv_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       instr_req_i,
    input  logic [`RAM_ADDR_WIDTH-1:0] instr_addr_i,
    output logic                       instr_gnt_o,
    output logic                       instr_rvalid_o,
    output logic [31:0]                instr_rdata_o,

    input  logic                       data_req_i,
    input  data_req_t                  data_req_bus_i,
    output logic                       data_gnt_o,
    output logic                       data_rvalid_o,
    output logic [31:0]                data_rdata_o,

    input  logic                       load_we_i,
    input  logic [`RAM_ADDR_WIDTH-1:0] load_addr_i,
    input  logic [31:0]                load_data_i,
    input  logic                       fetch_enable_i,

    output logic                       stdout_valid_o,
    output logic [7:0]                 stdout_char_o,
    output logic                       tests_passed_o,
    output logic                       tests_failed_o,
    output logic                       exit_valid_o,
    output logic [31:0]                exit_value_o
);

    localparam int WORD_AW = `RAM_ADDR_WIDTH - 2;

    logic [31:0]        mem [`RAM_WORDS];
    logic [WORD_AW-1:0] instr_idx;
    logic [WORD_AW-1:0] data_idx;
    logic               data_wr;
    logic               is_ram;
    logic [31:0]        instr_rdata_q;
    logic [31:0]        data_rdata_q;

    // data wins the single port, the fetch waits a cycle
    assign data_gnt_o  = data_req_i;
    assign instr_gnt_o = instr_req_i && !data_req_i;

    assign instr_idx = instr_addr_i[`RAM_ADDR_WIDTH-1:2];
    assign data_idx  = data_req_bus_i.addr[`RAM_ADDR_WIDTH-1:2];
    assign data_wr   = data_gnt_o && data_req_bus_i.we;
    assign is_ram    = (data_req_bus_i.addr[31:`RAM_ADDR_WIDTH] == '0);

    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem[load_addr_i[`RAM_ADDR_WIDTH-1:2]] <= load_data_i;
        end else if (data_wr && is_ram) begin
            for (int b = 0; b < 4; b++) begin
                if (data_req_bus_i.be[b]) begin
                    mem[data_idx][8*b +: 8] <= data_req_bus_i.wdata[8*b +: 8];
                end
            end
        end
        if (instr_gnt_o) begin
            instr_rdata_q <= mem[instr_idx];
        end
        // writes and peripheral reads answer with zero
        if (data_gnt_o) begin
            data_rdata_q <= (is_ram && !data_req_bus_i.we) ? mem[data_idx] : 32'd0;
        end
        if (data_wr && data_req_bus_i.addr == `STDOUT_ADDR) begin
            stdout_char_o <= data_req_bus_i.wdata[7:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
            stdout_valid_o <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= 32'd0;
        end else begin
            instr_rvalid_o <= instr_gnt_o;
            data_rvalid_o  <= data_gnt_o;
            stdout_valid_o <= data_wr && (data_req_bus_i.addr == `STDOUT_ADDR);
            exit_valid_o   <= data_wr && (data_req_bus_i.addr == `EXIT_ADDR);
            if (data_wr && data_req_bus_i.addr == `PASS_ADDR) begin
                tests_passed_o <= 1'b1;
            end
            if (data_wr && data_req_bus_i.addr == `FAIL_ADDR) begin
                tests_failed_o <= 1'b1;
            end
            if (data_wr && data_req_bus_i.addr == `EXIT_ADDR) begin
                exit_value_o <= data_req_bus_i.wdata;
            end
        end
    end

    assign instr_rdata_o = instr_rdata_q;
    assign data_rdata_o  = data_rdata_q;

    // the loader shares the port with a running core, so it must stay off
    a_load_while_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_we_i |-> !fetch_enable_i);

endmodule

// ==== hw/riscv_wrapper.sv ====
/*
 * Top level of the test system: the mini RV32I core fetching from and
 * storing to mm_ram, whose peripheral outputs report stdout characters,
 * pass/fail flags and the exit value to the testbench.
 */
`timescale 1ns/1ns
`include "mini_rv_config.svh"

module riscv_wrapper import mini_rv_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       fetch_enable_i,

    input  logic                       load_we_i,
    input  logic [`RAM_ADDR_WIDTH-1:0] load_addr_i,
    input  logic [31:0]                load_data_i,

    output logic                       tests_passed_o,
    output logic                       tests_failed_o,
    output logic                       exit_valid_o,
    output logic [31:0]                exit_value_o,
    output logic                       stdout_valid_o,
    output logic [7:0]                 stdout_char_o
);

    logic        instr_req;
    logic        instr_gnt;
    logic        instr_rvalid;
    logic [31:0] instr_addr;
    logic [31:0] instr_rdata;

    logic        data_req;
    logic        data_gnt;
    logic        data_rvalid;
    data_req_t   data_req_bus;
    logic [31:0] data_rdata;

    mini_rv_core core0 (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .instr_req_o    ( instr_req      ),
        .instr_addr_o   ( instr_addr     ),
        .instr_gnt_i    ( instr_gnt      ),
        .instr_rvalid_i ( instr_rvalid   ),
        .instr_rdata_i  ( instr_rdata    ),
        .data_req_o     ( data_req       ),
        .data_req_bus_o ( data_req_bus   ),
        .data_gnt_i     ( data_gnt       ),
        .data_rvalid_i  ( data_rvalid    ),
        .data_rdata_i   ( data_rdata     )
    );

    // only the low address bits reach the RAM on the fetch side
    mm_ram ram0 (
        .clk_i          ( clk_i                           ),
        .rst_n_i        ( rst_n_i                         ),
        .instr_req_i    ( instr_req                       ),
        .instr_addr_i   ( instr_addr[`RAM_ADDR_WIDTH-1:0] ),
        .instr_gnt_o    ( instr_gnt                       ),
        .instr_rvalid_o ( instr_rvalid                    ),
        .instr_rdata_o  ( instr_rdata                     ),
        .data_req_i     ( data_req                        ),
        .data_req_bus_i ( data_req_bus                    ),
        .data_gnt_o     ( data_gnt                        ),
        .data_rvalid_o  ( data_rvalid                     ),
        .data_rdata_o   ( data_rdata                      ),
        .load_we_i      ( load_we_i                       ),
        .load_addr_i    ( load_addr_i                     ),
        .load_data_i    ( load_data_i                     ),
        .fetch_enable_i ( fetch_enable_i                  ),
        .stdout_valid_o ( stdout_valid_o                  ),
        .stdout_char_o  ( stdout_char_o                   ),
        .tests_passed_o ( tests_passed_o                  ),
        .tests_failed_o ( tests_failed_o                  ),
        .exit_valid_o   ( exit_valid_o                    ),
        .exit_value_o   ( exit_value_o                    )
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
/*
 * Clock and reset source for the testbench. Makes a 100 ns clock and an
 * active low reset that is held for two rising edges from time zero and
 * again after each request from the testbench.
 */
`timescale 1ns/1ns

module tb_clock_gen (
    input  logic rst_req_i,
    output logic clk_o,
    output logic rst_n_o
);

    logic [1:0] hold_cnt = 2'd2;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // a request reloads the counter, reset releases when it runs out
    always @(posedge clk_o) begin
        if (rst_req_i) begin
            hold_cnt <= 2'd2;
        end else if (hold_cnt != 2'd0) begin
            hold_cnt <= hold_cnt - 2'd1;
        end
    end

    assign rst_n_o = (hold_cnt == 2'd0);

endmodule

// ==== bench/tb_riscv_wrapper.sv ====
/*
 * Testbench for riscv_wrapper. Reads program images and expected results
 * from bench/riscv_testdata.txt, then for each test resets the DUT, loads
 * the program through the loader port, starts the core and checks the
 * stdout characters, pass/fail flags, exit value and the halt afterwards.
 */
`timescale 1ns/1ns
`include "mini_rv_config.svh"

module tb_riscv_wrapper;

    logic                       clk;
    logic                       rst_n;
    logic                       rst_req;
    logic                       fetch_enable;
    logic                       load_we;
    logic [`RAM_ADDR_WIDTH-1:0] load_addr;
    logic [31:0]                load_data;
    logic                       tests_passed;
    logic                       tests_failed;
    logic                       exit_valid;
    logic [31:0]                exit_value;
    logic                       stdout_valid;
    logic [7:0]                 stdout_char;

    // program words and expected characters of all tests, back to back
    logic [31:0] prog_addr [$];
    logic [31:0] prog_word [$];
    logic [7:0]  exp_chars [$];
    int          word_first [$];
    int          word_count [$];
    int          char_first [$];
    int          char_count [$];
    bit          exp_passed [$];
    bit          exp_failed [$];
    logic [31:0] exp_exit [$];

    int err_cnt = 0;
    int check_cnt = 0;
    int cycle_cnt = 0;
    int timeout_limit = 0;
    bit file_ok;

    tb_clock_gen clk_gen0 (
        .rst_req_i ( rst_req ),
        .clk_o     ( clk     ),
        .rst_n_o   ( rst_n   )
    );

    riscv_wrapper dut0 (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .fetch_enable_i ( fetch_enable ),
        .load_we_i      ( load_we      ),
        .load_addr_i    ( load_addr    ),
        .load_data_i    ( load_data    ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_valid_o   ( exit_valid   ),
        .exit_value_o   ( exit_value   ),
        .stdout_valid_o ( stdout_valid ),
        .stdout_char_o  ( stdout_char  )
    );

    // inputs change 10 ns after the edge, outputs are read at the same point
    task automatic step_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic read_testdata(output bit ok);
        int            fd;
        int            code;
        int            pass_v;
        int            fail_v;
        int            words_in_test;
        int            chars_in_test;
        logic [7:0]    tag;
        logic [31:0]   val_a;
        logic [31:0]   val_b;
        logic [1023:0] line_buf;
        ok = 1'b0;
        words_in_test = 0;
        chars_in_test = 0;
        fd = $fopen("bench/riscv_testdata.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            code = $fscanf(fd, " %c", tag);
            while (code == 1 && ok) begin
                case (tag)
                    "#": begin
                        code = $fgets(line_buf, fd);
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h", val_a, val_b);
                        prog_addr.push_back(val_a);
                        prog_word.push_back(val_b);
                        words_in_test++;
                    end
                    "C": begin
                        code = $fscanf(fd, "%h", val_a);
                        exp_chars.push_back(val_a[7:0]);
                        chars_in_test++;
                    end
                    "E": begin
                        code = $fscanf(fd, "%d %d %h", pass_v, fail_v, val_a);
                        word_first.push_back(prog_addr.size() - words_in_test);
                        word_count.push_back(words_in_test);
                        char_first.push_back(exp_chars.size() - chars_in_test);
                        char_count.push_back(chars_in_test);
                        exp_passed.push_back(pass_v != 0);
                        exp_failed.push_back(fail_v != 0);
                        exp_exit.push_back(val_a);
                        words_in_test = 0;
                        chars_in_test = 0;
                    end
                    default: begin
                        $display("unknown line tag '%c' in the test data file", tag);
                        ok = 1'b0;
                    end
                endcase
                code = $fscanf(fd, " %c", tag);
            end
            $fclose(fd);
        end
        if (word_count.size() == 0) begin
            ok = 1'b0;
        end
        timeout_limit = 200 * prog_addr.size();
    endtask

    task automatic reset_dut(input int t);
        fetch_enable = 1'b0;
        rst_req = 1'b1;
        step_cycle();
        rst_req = 1'b0;
        while (!rst_n) begin
            step_cycle();
        end
        check_cnt++;
        if (stdout_valid !== 1'b0) begin
            $display("ERR stdout_valid_o after reset, test %0d: got 0x%h expected 0x0",
                     t, stdout_valid);
            err_cnt++;
        end
        if (exit_valid !== 1'b0) begin
            $display("ERR exit_valid_o after reset, test %0d: got 0x%h expected 0x0",
                     t, exit_valid);
            err_cnt++;
        end
        if (tests_passed !== 1'b0) begin
            $display("ERR tests_passed_o after reset, test %0d: got 0x%h expected 0x0",
                     t, tests_passed);
            err_cnt++;
        end
        if (tests_failed !== 1'b0) begin
            $display("ERR tests_failed_o after reset, test %0d: got 0x%h expected 0x0",
                     t, tests_failed);
            err_cnt++;
        end
    endtask

    task automatic load_program(input int t);
        int          k;
        logic [31:0] addr;
        for (k = word_first[t]; k < word_first[t] + word_count[t]; k++) begin
            addr      = prog_addr[k];
            load_we   = 1'b1;
            load_addr = addr[`RAM_ADDR_WIDTH-1:0];
            load_data = prog_word[k];
            step_cycle();
        end
        load_we = 1'b0;
    endtask

    task automatic run_program(input int t);
        int got_chars;
        int idx;
        int k;
        bit exit_seen;
        got_chars = 0;
        exit_seen = 1'b0;
        fetch_enable = 1'b1;
        while (!exit_seen) begin
            step_cycle();
            if (stdout_valid) begin
                if (got_chars >= char_count[t]) begin
                    $display("test %0d: extra stdout character 0x%02h after all %0d expected",
                             t, stdout_char, char_count[t]);
                    err_cnt++;
                end else begin
                    check_cnt++;
                    idx = char_first[t] + got_chars;
                    if (stdout_char !== exp_chars[idx]) begin
                        $display("ERR stdout_char_o test %0d char %0d: got 0x%02h expected 0x%02h",
                                 t, got_chars, stdout_char, exp_chars[idx]);
                        err_cnt++;
                    end
                end
                got_chars++;
            end
            exit_seen = exit_valid;
        end
        check_cnt += 4;
        if (exit_value !== exp_exit[t]) begin
            $display("ERR exit_value_o test %0d: got 0x%08h expected 0x%08h",
                     t, exit_value, exp_exit[t]);
            err_cnt++;
        end
        if (tests_passed !== exp_passed[t]) begin
            $display("ERR tests_passed_o test %0d: got 0x%h expected 0x%h",
                     t, tests_passed, exp_passed[t]);
            err_cnt++;
        end
        if (tests_failed !== exp_failed[t]) begin
            $display("ERR tests_failed_o test %0d: got 0x%h expected 0x%h",
                     t, tests_failed, exp_failed[t]);
            err_cnt++;
        end
        if (got_chars < char_count[t]) begin
            $display("test %0d: only %0d of %0d expected stdout characters before exit",
                     t, got_chars, char_count[t]);
            err_cnt++;
        end
        // the core sits in HALT now, so the outputs must stay quiet
        check_cnt++;
        for (k = 0; k < 50; k++) begin
            step_cycle();
            if (exit_valid) begin
                $display("test %0d: a second exit pulse came after the core halted", t);
                err_cnt++;
            end
            if (stdout_valid) begin
                $display("test %0d: stdout character 0x%02h came after the exit store",
                         t, stdout_char);
                err_cnt++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout after %0d cycles, the DUT never finished its tests", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rst_req = 1'b1;
        fetch_enable = 1'b0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = 32'd0;
        read_testdata(file_ok);
        if (!file_ok) begin
            $display("could not read any test from bench/riscv_testdata.txt");
            $display("Simulation FAILED");
            $finish;
        end else begin
            for (int t = 0; t < word_count.size(); t++) begin
                reset_dut(t);
                load_program(t);
                run_program(t);
            end
            $display("%0d tests, %0d checks, %0d errors", word_count.size(), check_cnt,
                     err_cnt);
            if (err_cnt == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== bench/riscv_testdata.txt ====
# P <byte address hex> <instruction hex>, C <stdout char code hex>
# E <passed 0/1> <failed 0/1> <exit value hex> closes each test
# arithmetic with LUI, ADDI, ADD and SUB
P 080 123450b7
P 084 67808093
P 088 11100113
P 08c 002081b3
P 090 ff000293
P 094 40518233
P 098 20000337
P 09c 00432423
P 0a0 00000000
E 0 0 12345799
# SW, SB and LW on one RAM word, result through the pass and fail flags
P 080 20000093
P 084 11223137
P 088 34410113
P 08c 0020a023
P 090 0ab00193
P 094 003080a3
P 098 0000a203
P 09c 1122b2b7
P 0a0 b4428293
P 0a4 20000337
P 0a8 00521663
P 0ac 00032023
P 0b0 0080006f
P 0b4 00032223
P 0b8 00432423
P 0bc 00000000
E 1 0 1122ab44
# BNE loop printing a countdown, then JAL into a routine and back
P 080 00500093
P 084 00000113
P 088 100003b7
P 08c 03008213
P 090 0043a023
P 094 00310113
P 098 fff08093
P 09c fe0098e3
P 0a0 010001ef
P 0a4 20000337
P 0a8 00232423
P 0ac 00000000
P 0b0 00310133
P 0b4 ff1ff06f
C 35
C 34
C 33
C 32
C 31
E 0 0 000000b3

// ==== files.f ====
+incdir+hw
hw/mini_rv_pkg.sv
hw/mini_rv_core.sv
hw/mm_ram.sv
hw/riscv_wrapper.sv
bench/tb_clock_gen.sv
bench/tb_riscv_wrapper.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f files.f --top-module tb_riscv_wrapper -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi
